// ==== hw/pbch_macros.svh ====
`ifndef PBCH_MACROS_SVH
`define PBCH_MACROS_SVH

// subcarriers in one frequency-domain symbol
`define PBCH_FFT_LEN 256

// DMRS pilots in the first PBCH symbol, one on every fourth subcarrier
`define PBCH_PILOTS 64

// Gold bits thrown away before the sequence is used (Nc in 38.211)
`define PBCH_GOLD_SKIP 1600

// both LFSRs of the Gold generator are 31 bits long
`define PBCH_LFSR_LEN 31

// one candidate DMRS sequence per SSB index ibar
`define PBCH_NUM_IBAR 8

// IQ sample with the real part in the low half and the imaginary part in the high half
`define PBCH_SAMPLE_W 32

// physical cell id, 0 to 1007
`define PBCH_NID_W 10

`endif

// ==== hw/pbch_pkg.sv ====
`include "pbch_macros.svh"

package pbch_pkg;

    // sequencing of the DMRS generation
    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_LOAD,
        GEN_SKIP,
        GEN_STORE,
        GEN_READY
    } gen_state_e;

    // ibar detection over one PBCH symbol
    typedef enum logic [1:0] {
        DET_IDLE,
        DET_COLLECT,
        DET_DECIDE
    } det_state_e;

    typedef logic [`PBCH_SAMPLE_W-1:0] sample_t;
    typedef logic [`PBCH_NID_W-1:0] n_id_t;
    typedef logic [$clog2(`PBCH_NUM_IBAR)-1:0] ibar_t;
    // bit 1 holds c(2k) and bit 0 holds c(2k+1)
    typedef logic [1:0] dmrs_sym_t;
    typedef logic [$clog2(`PBCH_PILOTS)-1:0] pilot_idx_t;
    // a full match gives two bits per pilot, so the count reaches 128
    typedef logic [$clog2(2 * `PBCH_PILOTS + 1)-1:0] corr_t;
    typedef logic [`PBCH_NUM_IBAR-1:0] gold_vec_t;

endpackage

// ==== hw/pbch_dmrs_ctrl.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module pbch_dmrs_ctrl (
    input  logic                                clk_i,
    input  logic                                reset_ni,
    input  logic                                n_id_valid_i,
    output logic                                gen_load_o,
    output logic                                gen_step_o,
    output logic                                wr_en_o,
    output logic [$clog2(2 * `PBCH_PILOTS)-1:0] wr_bit_idx_o,
    output logic                                dmrs_ready_o
);

    localparam int STORE_BITS = 2 * `PBCH_PILOTS;

    pbch_pkg::gen_state_e state_q;
    logic [$clog2(`PBCH_GOLD_SKIP)-1:0] step_cnt_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= pbch_pkg::GEN_IDLE;
            step_cnt_q   <= '0;
            dmrs_ready_o <= 1'b0;
        end else begin
            // ready follows the finished state one cycle later and drops with a new cell id
            dmrs_ready_o <= (state_q == pbch_pkg::GEN_READY) && !n_id_valid_i;
            if (n_id_valid_i) begin
                state_q    <= pbch_pkg::GEN_LOAD;
                step_cnt_q <= '0;
            end else begin
                case (state_q)
                    pbch_pkg::GEN_LOAD: begin
                        state_q    <= pbch_pkg::GEN_SKIP;
                        step_cnt_q <= '0;
                    end
                    pbch_pkg::GEN_SKIP: begin
                        if (step_cnt_q == `PBCH_GOLD_SKIP - 1) begin
                            state_q    <= pbch_pkg::GEN_STORE;
                            step_cnt_q <= '0;
                        end else begin
                            step_cnt_q <= step_cnt_q + 1'b1;
                        end
                    end
                    pbch_pkg::GEN_STORE: begin
                        if (step_cnt_q == STORE_BITS - 1) begin
                            state_q    <= pbch_pkg::GEN_READY;
                            step_cnt_q <= '0;
                        end else begin
                            step_cnt_q <= step_cnt_q + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign gen_load_o   = (state_q == pbch_pkg::GEN_LOAD);
    assign gen_step_o   = (state_q == pbch_pkg::GEN_SKIP) || (state_q == pbch_pkg::GEN_STORE);
    assign wr_en_o      = (state_q == pbch_pkg::GEN_STORE);
    assign wr_bit_idx_o = step_cnt_q[$clog2(STORE_BITS)-1:0];

    // the store is written in order from bit 0 and never while the pilots are in use
    a_write_order: assert property (@(posedge clk_i) disable iff (!reset_ni)
        wr_en_o |-> !dmrs_ready_o &&
            (wr_bit_idx_o == ($past(wr_en_o) ? $past(wr_bit_idx_o) + 1'b1 : '0)));

endmodule

// ==== hw/gold_seq_gen.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module gold_seq_gen (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  pbch_pkg::n_id_t     n_id_i,
    input  logic                load_i,
    input  logic                step_i,
    output pbch_pkg::gold_vec_t gold_o
);

    localparam int N = `PBCH_LFSR_LEN;

    logic [N-1:0] x1_q;
    logic [N-1:0] x2_q [0:`PBCH_NUM_IBAR-1];

    // PBCH DMRS seed from 38.211 section 7.4.1.4.1
    function automatic logic [N-1:0] calc_c_init(input int unsigned ibar,
                                                 input pbch_pkg::n_id_t n_id);
        logic [N-1:0] ib;
        logic [N-1:0] grp;
        ib  = N'(ibar + 1);
        grp = N'(n_id >> 2) + N'(1);
        return ((ib * grp) << 11) + (ib << 6) + N'(n_id[1:0]);
    endfunction

    // bit 0 of each register is the current sequence element x(n)
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1_q <= N'(1);
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                x2_q[i] <= '0;
            end
        end else if (load_i) begin
            x1_q <= N'(1);
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                x2_q[i] <= calc_c_init(i, n_id_i);
            end
        end else if (step_i) begin
            // x1(n+31) = x1(n+3) + x1(n)
            x1_q <= {x1_q[3] ^ x1_q[0], x1_q[N-1:1]};
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                // x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
                x2_q[i] <= {x2_q[i][3] ^ x2_q[i][2] ^ x2_q[i][1] ^ x2_q[i][0],
                            x2_q[i][N-1:1]};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            gold_o[i] = x1_q[0] ^ x2_q[i][0];
        end
    end

endmodule

// ==== hw/dmrs_store.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module dmrs_store (
    input  logic                                clk_i,
    input  logic                                wr_en_i,
    input  logic [$clog2(2 * `PBCH_PILOTS)-1:0] wr_bit_idx_i,
    input  pbch_pkg::gold_vec_t                 gold_i,
    input  pbch_pkg::pilot_idx_t                rd_idx_i,
    output pbch_pkg::dmrs_sym_t                 rd_sym_o [0:`PBCH_NUM_IBAR-1]
);

    pbch_pkg::dmrs_sym_t mem_q [0:`PBCH_NUM_IBAR-1][0:`PBCH_PILOTS-1];
    pbch_pkg::pilot_idx_t wr_pilot;

    // two Gold bits make one QPSK pilot
    assign wr_pilot = wr_bit_idx_i[$clog2(2 * `PBCH_PILOTS)-1:1];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
                // the even bit c(2k) lands in bit 1, the odd bit in bit 0
                if (wr_bit_idx_i[0]) begin
                    mem_q[i][wr_pilot][0] <= gold_i[i];
                end else begin
                    mem_q[i][wr_pilot][1] <= gold_i[i];
                end
            end
        end
    end

    // all eight candidates are read in parallel for the correlator
    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            rd_sym_o[i] = mem_q[i][rd_idx_i];
        end
    end

endmodule

// ==== hw/subcarrier_counter.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module subcarrier_counter (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  pbch_pkg::n_id_t      n_id_i,
    input  logic                 accept_i,
    input  logic                 start_i,
    output logic                 pilot_o,
    output logic                 last_o,
    output pbch_pkg::pilot_idx_t pilot_idx_o
);

    localparam int SC_W = $clog2(`PBCH_FFT_LEN);

    logic                 active_q;
    logic [SC_W-1:0]      sc_q;
    pbch_pkg::pilot_idx_t pilot_idx_q;
    logic                 in_sym;
    logic [SC_W-1:0]      cur_sc;

    // a start flag on the current sample restarts the count at subcarrier 0
    assign in_sym      = start_i || active_q;
    assign cur_sc      = start_i ? '0 : sc_q;
    assign pilot_idx_o = start_i ? '0 : pilot_idx_q;

    // pilots sit where (k - N_id) mod 4 is zero
    assign pilot_o = in_sym && (cur_sc[1:0] == n_id_i[1:0]);
    assign last_o  = in_sym && (cur_sc == SC_W'(`PBCH_FFT_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active_q    <= 1'b0;
            sc_q        <= '0;
            pilot_idx_q <= '0;
        end else if (accept_i && in_sym) begin
            active_q    <= !last_o;
            sc_q        <= cur_sc + 1'b1;
            pilot_idx_q <= pilot_idx_o + pbch_pkg::pilot_idx_t'(pilot_o);
        end
    end

endmodule

// ==== hw/ibar_correlator.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module ibar_correlator (
    input  logic                 clk_i,
    input  logic                 reset_ni,
    input  logic                 dmrs_ready_i,
    input  logic                 s_valid_i,
    input  logic                 pbch_start_i,
    input  pbch_pkg::sample_t    s_data_i,
    input  logic                 pilot_i,
    input  logic                 last_i,
    input  pbch_pkg::pilot_idx_t pilot_idx_i,
    input  pbch_pkg::dmrs_sym_t  rd_sym_i [0:`PBCH_NUM_IBAR-1],
    output pbch_pkg::pilot_idx_t rd_idx_o,
    output logic                 accept_o,
    output logic                 s_ready_o,
    output logic                 ibar_valid_o,
    output pbch_pkg::ibar_t      ibar_o
);

    localparam int HALF_W = `PBCH_SAMPLE_W / 2;

    pbch_pkg::det_state_e state_q;
    pbch_pkg::corr_t      corr_q [0:`PBCH_NUM_IBAR-1];
    pbch_pkg::corr_t      best_corr;
    pbch_pkg::ibar_t      best_idx;
    pbch_pkg::dmrs_sym_t  demod;
    logic [1:0]           hits [0:`PBCH_NUM_IBAR-1];
    logic                 acc_en;

    assign s_ready_o = dmrs_ready_i && (state_q != pbch_pkg::DET_DECIDE);
    assign accept_o  = s_valid_i && s_ready_o;
    assign rd_idx_o  = pilot_idx_i;
    assign acc_en    = accept_o && (pbch_start_i || state_q == pbch_pkg::DET_COLLECT);

    // hard decision on the sign bits, real part first
    assign demod = {s_data_i[HALF_W-1], s_data_i[`PBCH_SAMPLE_W-1]};

    always_comb begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            hits[i] = 2'(rd_sym_i[i][1] == demod[1]) + 2'(rd_sym_i[i][0] == demod[0]);
        end
    end

    // strict compare keeps the lowest ibar on a tie and gives 0 when all counts are zero
    always_comb begin
        best_idx  = '0;
        best_corr = corr_q[0];
        for (int i = 1; i < `PBCH_NUM_IBAR; i++) begin
            if (corr_q[i] > best_corr) begin
                best_corr = corr_q[i];
                best_idx  = pbch_pkg::ibar_t'(i);
            end
        end
    end

    // a start flag drops whatever was summed so far
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
            if (state_q == pbch_pkg::DET_DECIDE) begin
                corr_q[i] <= '0;
            end else if (acc_en) begin
                corr_q[i] <= (pbch_start_i ? pbch_pkg::corr_t'(0) : corr_q[i]) +
                             (pilot_i ? pbch_pkg::corr_t'(hits[i]) : pbch_pkg::corr_t'(0));
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= pbch_pkg::DET_IDLE;
            ibar_valid_o <= 1'b0;
            ibar_o       <= '0;
        end else begin
            ibar_valid_o <= 1'b0;
            case (state_q)
                pbch_pkg::DET_IDLE: begin
                    if (accept_o && pbch_start_i) begin
                        state_q <= pbch_pkg::DET_COLLECT;
                    end
                end
                pbch_pkg::DET_COLLECT: begin
                    if (accept_o && last_i) begin
                        state_q <= pbch_pkg::DET_DECIDE;
                    end
                end
                default: begin
                    ibar_o       <= best_idx;
                    ibar_valid_o <= 1'b1;
                    state_q      <= pbch_pkg::DET_IDLE;
                end
            endcase
        end
    end

    a_single_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_o |=> !ibar_valid_o);

endmodule

// ==== hw/pbch_dmrs_detector.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module pbch_dmrs_detector (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  pbch_pkg::n_id_t   N_id_i,
    input  logic              N_id_valid_i,
    input  pbch_pkg::sample_t s_data_i,
    input  logic              s_valid_i,
    input  logic              pbch_start_i,
    output logic              s_ready_o,
    output logic              dmrs_ready_o,
    output pbch_pkg::ibar_t   ibar_o,
    output logic              ibar_valid_o
);

    pbch_pkg::n_id_t                     n_id_q;
    logic                                gen_load;
    logic                                gen_step;
    logic                                wr_en;
    logic [$clog2(2 * `PBCH_PILOTS)-1:0] wr_bit_idx;
    pbch_pkg::gold_vec_t                 gold_bits;
    pbch_pkg::pilot_idx_t                rd_idx;
    pbch_pkg::dmrs_sym_t                 rd_sym [0:`PBCH_NUM_IBAR-1];
    logic                                pilot;
    logic                                last;
    pbch_pkg::pilot_idx_t                pilot_idx;
    logic                                accept;

    // the cell id is held here and feeds both the seed and the pilot offset
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            n_id_q <= '0;
        end else if (N_id_valid_i) begin
            n_id_q <= N_id_i;
        end
    end

    pbch_dmrs_ctrl dmrs_ctrl_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_valid_i (N_id_valid_i),
        .gen_load_o   (gen_load),
        .gen_step_o   (gen_step),
        .wr_en_o      (wr_en),
        .wr_bit_idx_o (wr_bit_idx),
        .dmrs_ready_o (dmrs_ready_o)
    );

    gold_seq_gen gold_seq_gen_i (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .n_id_i   (n_id_q),
        .load_i   (gen_load),
        .step_i   (gen_step),
        .gold_o   (gold_bits)
    );

    dmrs_store dmrs_store_i (
        .clk_i        (clk_i),
        .wr_en_i      (wr_en),
        .wr_bit_idx_i (wr_bit_idx),
        .gold_i       (gold_bits),
        .rd_idx_i     (rd_idx),
        .rd_sym_o     (rd_sym)
    );

    subcarrier_counter subcarrier_counter_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .n_id_i      (n_id_q),
        .accept_i    (accept),
        .start_i     (pbch_start_i),
        .pilot_o     (pilot),
        .last_o      (last),
        .pilot_idx_o (pilot_idx)
    );

    ibar_correlator ibar_correlator_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .dmrs_ready_i (dmrs_ready_o),
        .s_valid_i    (s_valid_i),
        .pbch_start_i (pbch_start_i),
        .s_data_i     (s_data_i),
        .pilot_i      (pilot),
        .last_i       (last),
        .pilot_idx_i  (pilot_idx),
        .rd_sym_i     (rd_sym),
        .rd_idx_o     (rd_idx),
        .accept_o     (accept),
        .s_ready_o    (s_ready_o),
        .ibar_valid_o (ibar_valid_o),
        .ibar_o       (ibar_o)
    );

endmodule

// ==== tests/tb_pbch_ref.svh ====
`ifndef TB_PBCH_REF_SVH
`define TB_PBCH_REF_SVH

// Gold sequence c(n) for n = 0 to 127 straight from the 38.211 recurrences
function automatic logic [2*`PBCH_PILOTS-1:0] gold_seq(input int ibar, input int n_id);
    logic x1 [0:`PBCH_GOLD_SKIP + 2*`PBCH_PILOTS - 1];
    logic x2 [0:`PBCH_GOLD_SKIP + 2*`PBCH_PILOTS - 1];
    logic [31:0] c_init;
    logic [2*`PBCH_PILOTS-1:0] c;
    c_init = (ibar + 1) * (n_id / 4 + 1) * 2048 + (ibar + 1) * 64 + n_id % 4;
    for (int n = 0; n < `PBCH_LFSR_LEN; n++) begin
        x1[n] = (n == 0);
        x2[n] = c_init[n];
    end
    for (int n = 0; n + `PBCH_LFSR_LEN < `PBCH_GOLD_SKIP + 2*`PBCH_PILOTS; n++) begin
        x1[n+`PBCH_LFSR_LEN] = x1[n+3] ^ x1[n];
        x2[n+`PBCH_LFSR_LEN] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
    end
    // pilot k is the pair c(2k), c(2k+1)
    for (int n = 0; n < 2*`PBCH_PILOTS; n++) begin
        c[n] = x1[n+`PBCH_GOLD_SKIP] ^ x2[n+`PBCH_GOLD_SKIP];
    end
    return c;
endfunction

// received pilot bits use the same layout as c(n); the lowest ibar wins a tie
function automatic pbch_pkg::ibar_t expected_ibar(input logic [2*`PBCH_PILOTS-1:0] rx,
                                                  input int n_id);
    logic [2*`PBCH_PILOTS-1:0] seq;
    int best;
    int best_cnt;
    int cnt;
    best     = 0;
    best_cnt = -1;
    for (int i = 0; i < `PBCH_NUM_IBAR; i++) begin
        seq = gold_seq(i, n_id);
        cnt = 0;
        for (int b = 0; b < 2*`PBCH_PILOTS; b++) begin
            if (seq[b] == rx[b]) begin
                cnt++;
            end
        end
        if (cnt > best_cnt) begin
            best_cnt = cnt;
            best     = i;
        end
    end
    return pbch_pkg::ibar_t'(best);
endfunction

// Galois LFSR on lfsr_state of the including module, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < nbits; b++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
endfunction

// signs are fixed by the pilot, the magnitudes are random
function automatic pbch_pkg::sample_t build_sample(input logic re_sign, input logic im_sign);
    logic [31:0] re_mag;
    logic [31:0] im_mag;
    re_mag = lfsr_bits(`PBCH_SAMPLE_W / 2 - 1);
    im_mag = lfsr_bits(`PBCH_SAMPLE_W / 2 - 1);
    return {im_sign, im_mag[`PBCH_SAMPLE_W/2-2:0], re_sign, re_mag[`PBCH_SAMPLE_W/2-2:0]};
endfunction

`endif

// ==== tests/tb_pbch_dmrs_detector.sv ====
`timescale 1ns/1ns
`include "pbch_macros.svh"

module tb_pbch_dmrs_detector;

    // load, skip, store and the ready register
    localparam int READY_EDGES    = 2 + `PBCH_GOLD_SKIP + 2 * `PBCH_PILOTS;
    // roughly ten rounds of generation plus one symbol
    localparam int TIMEOUT_CYCLES = 10 * 2100;

    logic              clk_i;
    logic              reset_ni;
    pbch_pkg::n_id_t   N_id_i;
    logic              N_id_valid_i;
    pbch_pkg::sample_t s_data_i;
    logic              s_valid_i;
    logic              pbch_start_i;
    logic              s_ready_o;
    logic              dmrs_ready_o;
    pbch_pkg::ibar_t   ibar_o;
    logic              ibar_valid_o;

    logic [31:0]       lfsr_state = 32'hd336_5a94;
    int                cur_nid;
    int                cycles;
    pbch_pkg::ibar_t   exp_q [$];

    `include "tb_pbch_ref.svh"

    pbch_dmrs_detector DUT (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .N_id_i       (N_id_i),
        .N_id_valid_i (N_id_valid_i),
        .s_data_i     (s_data_i),
        .s_valid_i    (s_valid_i),
        .pbch_start_i (pbch_start_i),
        .s_ready_o    (s_ready_o),
        .dmrs_ready_o (dmrs_ready_o),
        .ibar_o       (ibar_o),
        .ibar_valid_o (ibar_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_ibar(input pbch_pkg::ibar_t actual, input pbch_pkg::ibar_t expected);
        if (actual !== expected) begin
            report_error($sformatf("FAIL at %0t ns: ibar_o expected %0d, got %0d",
                                   $time, expected, actual));
        end
    endtask

    task automatic check_ready(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_error($sformatf("FAIL at %0t ns: %s expected %b, got %b",
                                   $time, name, expected, actual));
        end
    endtask

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_error("timeout: the run did not finish within the cycle limit");
        end
    end

    // every result pulse must match the oldest symbol still waiting
    always @(posedge clk_i) begin
        if (reset_ni && ibar_valid_o) begin
            if (exp_q.size() == 0) begin
                report_error("ibar_valid_o pulsed while no PBCH symbol was pending");
            end else begin
                check_ibar(ibar_o, exp_q.pop_front());
            end
        end
    end

    task automatic load_cell_id(input int n_id);
        @(posedge clk_i);
        #10;
        N_id_i       = pbch_pkg::n_id_t'(n_id);
        N_id_valid_i = 1'b1;
        cur_nid      = n_id;
        @(posedge clk_i);
        #10;
        N_id_valid_i = 1'b0;
        check_ready("dmrs_ready_o", dmrs_ready_o, 1'b0);
        for (int k = 1; k <= READY_EDGES; k++) begin
            @(posedge clk_i);
            #1;
            check_ready("dmrs_ready_o", dmrs_ready_o, k == READY_EDGES);
            check_ready("s_ready_o", s_ready_o, k == READY_EDGES);
        end
    endtask

    task automatic drive_sample(input int sc, input logic [2*`PBCH_PILOTS-1:0] rx,
                                input bit gaps);
        int k;
        k = sc / 4;
        if (sc % 4 == cur_nid % 4) begin
            s_data_i = build_sample(rx[2*k], rx[2*k+1]);
        end else begin
            s_data_i = lfsr_bits(`PBCH_SAMPLE_W);
        end
        pbch_start_i = (sc == 0);
        s_valid_i    = !(gaps && lfsr_bits(2) == 0);
    endtask

    task automatic send_symbol(input int ibar, input int flips, input bit gaps);
        logic [2*`PBCH_PILOTS-1:0] rx;
        logic [31:0] pos;
        int sc;
        rx = gold_seq(ibar, cur_nid);
        for (int f = 0; f < flips; f++) begin
            pos = lfsr_bits(7);
            rx[pos[6:0]] = ~rx[pos[6:0]];
        end
        // a clean symbol must return its own ibar
        if (flips == 0) begin
            exp_q.push_back(pbch_pkg::ibar_t'(ibar));
        end else begin
            exp_q.push_back(expected_ibar(rx, cur_nid));
        end
        sc = 0;
        @(posedge clk_i);
        #10;
        drive_sample(sc, rx, gaps);
        while (sc < `PBCH_FFT_LEN) begin
            @(posedge clk_i);
            if (s_valid_i && s_ready_o) begin
                sc++;
            end
            #10;
            if (sc < `PBCH_FFT_LEN) begin
                drive_sample(sc, rx, gaps);
            end else begin
                s_valid_i    = 1'b0;
                pbch_start_i = 1'b0;
            end
        end
    endtask

    // samples outside a PBCH symbol must be swallowed without a result
    task automatic send_idle(input int n);
        int cnt;
        cnt = 0;
        @(posedge clk_i);
        #10;
        s_data_i  = lfsr_bits(`PBCH_SAMPLE_W);
        s_valid_i = 1'b1;
        while (cnt < n) begin
            @(posedge clk_i);
            if (s_valid_i && s_ready_o) begin
                cnt++;
            end
            #10;
            s_data_i  = lfsr_bits(`PBCH_SAMPLE_W);
            s_valid_i = (cnt < n);
        end
    endtask

    task automatic wait_result();
        // the decision cycle right after the last sample holds off new input
        check_ready("s_ready_o", s_ready_o, 1'b0);
        for (int k = 0; k < 8; k++) begin
            @(posedge clk_i);
            #1;
            if (exp_q.size() == 0) begin
                return;
            end
        end
        report_error("no ibar_valid_o pulse came after a complete PBCH symbol");
    endtask

    initial begin
        int cell_ids [0:4];
        cell_ids     = '{88, 1005, 214, 503, 733};
        cycles       = 0;
        cur_nid      = 0;
        reset_ni     = 1'b0;
        N_id_i       = '0;
        N_id_valid_i = 1'b0;
        s_data_i     = '0;
        s_valid_i    = 1'b0;
        pbch_start_i = 1'b0;
        repeat (5) @(posedge clk_i);
        #10;
        reset_ni = 1'b1;
        @(posedge clk_i);
        #1;
        check_ready("dmrs_ready_o", dmrs_ready_o, 1'b0);
        check_ready("s_ready_o", s_ready_o, 1'b0);
        check_ready("ibar_valid_o", ibar_valid_o, 1'b0);
        check_ibar(ibar_o, '0);

        // clean symbols for every ibar, one cell id per residue mod 4
        for (int c = 0; c < 4; c++) begin
            load_cell_id(cell_ids[c]);
            send_symbol(2 * c, 0, 1'b0);
            wait_result();
            send_symbol(2 * c + 1, 0, 1'b0);
            wait_result();
        end

        repeat (4) begin
            send_symbol(int'(lfsr_bits(3)), 20, 1'b0);
            wait_result();
        end

        repeat (3) begin
            send_idle(int'(lfsr_bits(4)) + 3);
            send_symbol(int'(lfsr_bits(3)), 0, 1'b1);
            wait_result();
        end

        // a new cell id while ready regenerates all eight sequences
        load_cell_id(cell_ids[4]);
        repeat (2) begin
            send_idle(int'(lfsr_bits(3)) + 1);
            send_symbol(int'(lfsr_bits(3)), 8, 1'b1);
            wait_result();
        end

        repeat (4) @(posedge clk_i);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
+incdir+tests
hw/pbch_pkg.sv
hw/pbch_dmrs_ctrl.sv
hw/gold_seq_gen.sv
hw/dmrs_store.sv
hw/subcarrier_counter.sv
hw/ibar_correlator.sv
hw/pbch_dmrs_detector.sv
tests/tb_pbch_dmrs_detector.sv

// ==== Bender.yml ====
package:
  name: pbch_dmrs_detector

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/pbch_pkg.sv
      - hw/pbch_dmrs_ctrl.sv
      - hw/gold_seq_gen.sv
      - hw/dmrs_store.sv
      - hw/subcarrier_counter.sv
      - hw/ibar_correlator.sv
      - hw/pbch_dmrs_detector.sv
  - target: test
    include_dirs:
      - hw
      - tests
    files:
      - tests/tb_pbch_dmrs_detector.sv
